// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = motion_tb
FILELIST  = list.f
BUILD_DIR = obj_dir
RUN_FLAGS = +verilator+error+limit+1000000
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "Testbench passed" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/motion_assert.sv
`timescale 1ns/10ps

module motion_assert (
	input logic                                clock,
	input logic                                rst_n,
	input logic                                pixel_valid,
	input logic [motion_pkg::x_width-1:0]      pixel_x,
	input logic [motion_pkg::y_width-1:0]      pixel_y,
	input logic [motion_pkg::colour_width-1:0] pixel_colour,
	input logic                                frame_start,
	input logic                                smoothing,
	input logic                                plot,
	input logic [motion_pkg::x_width-1:0]      plot_x,
	input logic [motion_pkg::y_width-1:0]      plot_y,
	input logic                                plot_colour,
	input logic                                frame_done,
	input logic [motion_pkg::count_width-1:0]  motion_count,
	input logic                                motion_detected
);
	import motion_pkg::*;

	localparam int n_pixels = image_w * image_h;

	logic [colour_width-1:0] shadow_frame [n_pixels];
	logic                    shadow_mask [n_pixels];
	pix_addr_t               pixel_addr;
	logic                    started;
	logic                    scanning;
	logic [x_width-1:0]      exp_x;
	logic [y_width-1:0]      exp_y;
	int                      plot_total;
	logic [count_width-1:0]  exp_count;
	logic                    exp_bit;
	int                      fail_count = 0;

	function automatic logic mask_at(input int x, input int y);
		if (x < 0 || y < 0 || x >= image_w || y >= image_h) begin
			return 1'b0;   // outside the image
		end
		return shadow_mask[y * image_w + x];
	endfunction

	assign pixel_addr = pix_addr_t'(pixel_y * image_w + pixel_x);

	always_ff @(posedge clock) begin
		if (pixel_valid) begin
			shadow_mask[pixel_addr] <= (shadow_frame[pixel_addr] != pixel_colour);
			shadow_frame[pixel_addr] <= pixel_colour;
		end
	end

	// erosion over the 3x3 neighbourhood in smoothing mode
	always_comb begin
		exp_bit = mask_at(int'(plot_x), int'(plot_y));
		if (smoothing) begin
			for (int dy = -1; dy <= 1; dy++) begin
				for (int dx = -1; dx <= 1; dx++) begin
					exp_bit = exp_bit & mask_at(int'(plot_x) + dx, int'(plot_y) + dy);
				end
			end
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			started <= 1'b0;
			scanning <= 1'b0;
			exp_x <= '0;
			exp_y <= '0;
			plot_total <= 0;
			exp_count <= '0;
		end else begin
			if (frame_done) begin
				scanning <= 1'b0;
			end
			// scanner is already idle when frame_done shows
			if (frame_start && (!scanning || frame_done)) begin
				started <= 1'b1;
				scanning <= 1'b1;
				exp_x <= '0;
				exp_y <= '0;
				plot_total <= 0;
				exp_count <= '0;
			end else if (plot) begin
				plot_total <= plot_total + 1;
				exp_count <= exp_count + exp_bit;
				exp_x <= exp_x + 1'b1;   // wraps at image_w
				if (exp_x == image_w - 1) begin
					exp_y <= exp_y + 1'b1;
				end
			end
		end
	end

	a_quiet: assert property (@(posedge clock) disable iff (!rst_n)
		!started |-> !plot && !frame_done && !motion_detected)
		else begin
			fail_count = fail_count + 1;
			$error("plot, frame_done or motion_detected went high before any frame_start");
		end

	a_plot_bit: assert property (@(posedge clock) disable iff (!rst_n)
		plot |-> plot_colour == exp_bit)
		else begin
			fail_count = fail_count + 1;
			$error("ERR plot_colour at %h,%h exp %h got %h", plot_x, plot_y, exp_bit, plot_colour);
		end

	a_raster: assert property (@(posedge clock) disable iff (!rst_n)
		plot |-> plot_x == exp_x && plot_y == exp_y)
		else begin
			fail_count = fail_count + 1;
			$error("ERR plot_x,plot_y exp %h,%h got %h,%h", exp_x, exp_y, plot_x, plot_y);
		end

	a_plot_total: assert property (@(posedge clock) disable iff (!rst_n)
		frame_done |-> plot_total == n_pixels)
		else begin
			fail_count = fail_count + 1;
			$error("ERR plot count exp %h got %h", n_pixels, plot_total);
		end

	a_done_after_last: assert property (@(posedge clock) disable iff (!rst_n)
		frame_done |-> $past(plot) && $past(plot_x) == image_w - 1 && $past(plot_y) == image_h - 1)
		else begin
			fail_count = fail_count + 1;
			$error("frame_done did not come right after the last plot of the frame");
		end

	a_count: assert property (@(posedge clock) disable iff (!rst_n)
		frame_done |-> motion_count == exp_count)
		else begin
			fail_count = fail_count + 1;
			$error("ERR motion_count exp %h got %h", exp_count, motion_count);
		end

	a_detect: assert property (@(posedge clock) disable iff (!rst_n)
		frame_done |-> motion_detected == (exp_count >= motion_threshold))
		else begin
			fail_count = fail_count + 1;
			$error("ERR motion_detected exp %h got %h",
				exp_count >= motion_threshold, motion_detected);
		end

	a_hold: assert property (@(posedge clock) disable iff (!rst_n)
		!frame_done |-> $stable(motion_count) && $stable(motion_detected))
		else begin
			fail_count = fail_count + 1;
			$error("motion_count or motion_detected changed without frame_done");
		end

endmodule

// File: bench/motion_tb.sv
`timescale 1ns/10ps

module motion_tb;
	import motion_pkg::*;

	localparam int n_pixels = image_w * image_h;
	localparam int n_frames = 13;   // frames fed plus scans run
	localparam longint watchdog_ns = longint'(6) * n_frames * n_pixels * 8 * 20;

	logic                    clock;
	logic                    rst_n;
	logic                    pixel_valid;
	logic [x_width-1:0]      pixel_x;
	logic [y_width-1:0]      pixel_y;
	logic [colour_width-1:0] pixel_colour;
	logic                    frame_start;
	logic                    smoothing;
	logic                    plot;
	logic [x_width-1:0]      plot_x;
	logic [y_width-1:0]      plot_y;
	logic                    plot_colour;
	logic                    frame_done;
	logic [count_width-1:0]  motion_count;
	logic                    motion_detected;

	logic [colour_width-1:0] sent_frame [n_pixels];   // last colour sent per pixel
	int                      test_num;
	int                      tests_failed;
	int                      errors_before;

	bind motion_top motion_assert u_check (
		.clock           (clock),
		.rst_n           (rst_n),
		.pixel_valid     (pixel_valid),
		.pixel_x         (pixel_x),
		.pixel_y         (pixel_y),
		.pixel_colour    (pixel_colour),
		.frame_start     (frame_start),
		.smoothing       (smoothing),
		.plot            (plot),
		.plot_x          (plot_x),
		.plot_y          (plot_y),
		.plot_colour     (plot_colour),
		.frame_done      (frame_done),
		.motion_count    (motion_count),
		.motion_detected (motion_detected)
	);

	motion_top u_dut (.*);

	always #10 clock = ~clock;

	// called on a falling edge, returns on the next one
	task automatic send_pixel(input int x, input int y, input logic [colour_width-1:0] c);
		pixel_valid = 1'b1;
		pixel_x = x_width'(x);
		pixel_y = y_width'(y);
		pixel_colour = c;
		sent_frame[y * image_w + x] = c;
		@(negedge clock);
		pixel_valid = 1'b0;
	endtask

	// fresh frame is random, otherwise colours change only inside the rectangle
	task automatic send_frame(input int x0, input int y0, input int w, input int h,
			input bit fresh);
		logic [colour_width-1:0] c;
		for (int y = 0; y < image_h; y++) begin
			for (int x = 0; x < image_w; x++) begin
				c = sent_frame[y * image_w + x];
				if (fresh) begin
					c = colour_width'($urandom);
				end else if (x >= x0 && x < x0 + w && y >= y0 && y < y0 + h) begin
					c = c ^ colour_width'(1 + $urandom_range(6));   // never the same colour
				end
				send_pixel(x, y, c);
			end
		end
		repeat (4) @(negedge clock);   // last writes land
	endtask

	task automatic start_scan(input logic smooth);
		smoothing = smooth;
		frame_start = 1'b1;
		@(negedge clock);
		frame_start = 1'b0;
	endtask

	task automatic wait_frame_done();
		while (!frame_done) begin
			@(negedge clock);
		end
	endtask

	task automatic end_test(input string name);
		int errs;
		errs = u_dut.u_check.fail_count - errors_before;
		test_num++;
		if (errs != 0) begin
			tests_failed++;
		end
		$display("test %0d %s: %s, %0d assertion errors", test_num, name,
			(errs == 0) ? "ok" : "FAILED", errs);
		errors_before = u_dut.u_check.fail_count;
	endtask

	initial begin
		void'($urandom(32'hc06e));
		clock = 1'b0;
		rst_n = 1'b0;
		pixel_valid = 1'b0;
		pixel_x = '0;
		pixel_y = '0;
		pixel_colour = '0;
		frame_start = 1'b0;
		smoothing = 1'b0;
		test_num = 0;
		tests_failed = 0;
		errors_before = 0;
		repeat (16) @(negedge clock);
		rst_n = 1'b1;
		repeat (50) @(negedge clock);
		end_test("quiet after reset");

		send_frame(0, 0, 0, 0, 1'b1);
		send_frame(20, 10, 8, 4, 1'b0);
		start_scan(1'b0);
		wait_frame_done();
		end_test("raw mode small rectangle");

		start_scan(1'b1);
		wait_frame_done();
		end_test("smoothing mode small rectangle");

		send_frame(8, 16, 24, 12, 1'b0);
		start_scan(1'b0);
		wait_frame_done();
		end_test("large rectangle sets motion");

		// every mask bit set, only the border erodes away
		send_frame(0, 0, image_w, image_h, 1'b0);
		start_scan(1'b1);
		wait_frame_done();
		end_test("smoothing mode edges plot zero");

		send_frame(0, 0, 0, 0, 1'b0);   // identical frame
		start_scan(1'b0);
		wait_frame_done();
		end_test("unchanged frame clears motion");

		// rows 0 to 9 rewritten while the window sits near row 20
		start_scan(1'b0);
		while (!(plot && plot_y == 20)) begin
			@(negedge clock);
		end
		for (int y = 0; y < 10; y++) begin
			for (int x = 0; x < image_w; x++) begin
				send_pixel(x, y, colour_width'($urandom));
			end
		end
		wait_frame_done();
		end_test("scan with concurrent writes");

		repeat (4) @(negedge clock);
		start_scan(1'b0);
		wait_frame_done();
		end_test("rescan shows the writes");

		$display("tests run %0d, tests failed %0d, assertion errors %0d",
			test_num, tests_failed, u_dut.u_check.fail_count);
		if (tests_failed == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	initial begin
		#(watchdog_ns);
		$display("watchdog timeout, scan never finished");
		$display("Testbench failed");
		$finish;
	end

endmodule

// File: design/diff_engine.sv
`timescale 1ns/10ps

module diff_engine (
	input  logic                                 clock,
	input  logic                                 rst_n,
	input  logic                                 pixel_valid,
	input  logic [motion_pkg::x_width-1:0]      pixel_x,
	input  logic [motion_pkg::y_width-1:0]      pixel_y,
	input  logic [motion_pkg::colour_width-1:0] pixel_colour,
	output motion_pkg::pix_addr_t                fs_rd_addr,
	input  logic [motion_pkg::colour_width-1:0] fs_rd_colour,
	output logic                                 fs_wr_en,
	output motion_pkg::pix_addr_t                fs_wr_addr,
	output logic [motion_pkg::colour_width-1:0] fs_wr_colour,
	output logic                                 mask_wr,
	output motion_pkg::pix_addr_t                mask_addr,
	output logic                                 mask_bit
);
	import motion_pkg::*;

	logic                    s1_valid;
	pix_addr_t               s1_addr;
	logic [colour_width-1:0] s1_colour;

	// stage one: frame store lookup runs alongside the pixel register
	assign fs_rd_addr = pix_addr_t'(pixel_y * image_w + pixel_x);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			fs_wr_en <= 1'b0;
		end else begin
			s1_valid <= pixel_valid;
			fs_wr_en <= s1_valid;
		end
	end

	always_ff @(posedge clock) begin
		s1_addr <= fs_rd_addr;
		s1_colour <= pixel_colour;
		// stage two
		fs_wr_addr <= s1_addr;
		fs_wr_colour <= s1_colour;
		mask_bit <= (fs_rd_colour != s1_colour);   // changed since last frame
	end

	// mask write shares the frame store write slot
	assign mask_wr = fs_wr_en;
	assign mask_addr = fs_wr_addr;

endmodule

// File: design/frame_store.sv
`timescale 1ns/10ps

module frame_store (
	input  logic                                 clock,
	input  motion_pkg::pix_addr_t                rd_addr,
	output logic [motion_pkg::colour_width-1:0] rd_colour,
	input  logic                                 wr_en,
	input  motion_pkg::pix_addr_t                wr_addr,
	input  logic [motion_pkg::colour_width-1:0] wr_colour
);
	import motion_pkg::*;

	// previous frame, one colour per pixel
	logic [colour_width-1:0] mem [image_w*image_h];

	always_ff @(posedge clock) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_colour;
		end
	end

	always_ff @(posedge clock) begin
		rd_colour <= mem[rd_addr];   // one cycle read
	end

endmodule

// File: design/mask_arbiter.sv
`timescale 1ns/10ps

module mask_arbiter (
	input  logic                  clock,
	input  logic                  rst_n,
	input  logic                  wr_strobe,
	input  motion_pkg::pix_addr_t wr_addr,
	input  logic                  wr_bit,
	input  logic                  rd_req,
	input  motion_pkg::pix_addr_t rd_addr,
	output logic                  rd_grant,
	output logic                  rd_valid,
	output logic                  rd_bit
);
	import motion_pkg::*;

	logic      ram_en;
	pix_addr_t ram_addr;

	// writer never waits
	assign rd_grant = rd_req && !wr_strobe;

	assign ram_en = wr_strobe || rd_grant;
	assign ram_addr = wr_strobe ? wr_addr : rd_addr;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= rd_grant;   // data lands one cycle after grant
		end
	end

	mask_ram u_mask_ram (
		.clock (clock),
		.en    (ram_en),
		.we    (wr_strobe),
		.addr  (ram_addr),
		.wdata (wr_bit),
		.rdata (rd_bit)
	);

endmodule

// File: design/mask_ram.sv
`timescale 1ns/10ps

module mask_ram (
	input  logic                  clock,
	input  logic                  en,
	input  logic                  we,
	input  motion_pkg::pix_addr_t addr,
	input  logic                  wdata,
	output logic                  rdata
);
	import motion_pkg::*;

	logic mem [image_w*image_h];

	// single port, write or read per cycle
	always_ff @(posedge clock) begin
		if (en) begin
			if (we) begin
				mem[addr] <= wdata;
			end else begin
				rdata <= mem[addr];
			end
		end
	end

endmodule

// File: design/mask_scanner.sv
`timescale 1ns/10ps

module mask_scanner (
	input  logic                                clock,
	input  logic                                rst_n,
	input  logic                                frame_start,
	input  logic                                smoothing,
	output logic                                rd_req,
	output motion_pkg::pix_addr_t               rd_addr,
	input  logic                                rd_grant,
	input  logic                                rd_valid,
	input  logic                                rd_bit,
	output logic                                plot,
	output logic [motion_pkg::x_width-1:0]     plot_x,
	output logic [motion_pkg::y_width-1:0]     plot_y,
	output logic                                plot_colour,
	output logic                                frame_done,
	output logic [motion_pkg::count_width-1:0] motion_count,
	output logic                                motion_detected
);
	import motion_pkg::*;

	scan_state_t             state;
	logic [x_width:0]        col;       // column being loaded, one past the centre
	logic [y_width-1:0]      cy;
	logic [1:0]              row;       // 0 above, 1 same, 2 below
	logic [y_width:0]        ry;
	logic [2:0]              col_bits;
	logic [2:0]              win_a;     // two columns left of col
	logic [2:0]              win_b;     // centre column
	logic [count_width-1:0]  count;
	logic                    last_plot;
	logic                    in_image;
	logic                    bit_done;
	logic                    bit_val;
	logic                    plot_bit;

	assign ry = {1'b0, cy} + row - 1'b1;   // wraps high above row 0
	assign in_image = (ry < image_h) && (col < image_w);

	assign rd_req = (state == request) && in_image;
	assign rd_addr = pix_addr_t'(ry * image_w + col);

	// outside the image reads as zero without a memory access
	assign bit_done = ((state == request) && !in_image) || ((state == wait_data) && rd_valid);
	assign bit_val = (state == wait_data) && rd_bit;

	// erosion needs all nine
	assign plot_bit = smoothing ? &{win_a, win_b, col_bits} : win_b[1];

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state <= idle;
			col <= '0;
			cy <= '0;
			row <= '0;
			win_a <= '0;
			win_b <= '0;
			count <= '0;
			last_plot <= 1'b0;
			plot <= 1'b0;
			frame_done <= 1'b0;
			motion_count <= '0;
			motion_detected <= 1'b0;
		end else begin
			plot <= 1'b0;
			last_plot <= 1'b0;
			frame_done <= last_plot;
			if (last_plot) begin
				motion_count <= count;
				motion_detected <= (count >= motion_threshold);
			end
			case (state)
				idle: begin
					if (frame_start) begin
						col <= '0;
						cy <= '0;
						row <= '0;
						win_a <= '0;
						win_b <= '0;
						count <= '0;
						state <= request;
					end
				end
				request, wait_data: begin
					if (rd_grant) begin
						state <= wait_data;
					end
					if (bit_done) begin
						if (row == 2'd2) begin
							row <= '0;
							state <= emit;
						end else begin
							row <= row + 1'b1;
							state <= request;
						end
					end
				end
				emit: begin
					win_a <= win_b;
					win_b <= col_bits;
					plot <= (col != 0);   // first column only primes the window
					if (col != 0 && plot_bit) begin
						count <= count + 1'b1;
					end
					if (col == image_w) begin
						col <= '0;
						win_a <= '0;
						win_b <= '0;
						if (cy == image_h - 1) begin
							last_plot <= 1'b1;
							state <= idle;
						end else begin
							cy <= cy + 1'b1;
							state <= request;
						end
					end else begin
						col <= col + 1'b1;
						state <= request;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (bit_done) begin
			col_bits[row] <= bit_val;
		end
		if (state == emit) begin
			plot_x <= x_width'(col - 1'b1);
			plot_y <= cy;
			plot_colour <= plot_bit;
		end
	end

endmodule

// File: design/motion_pkg.sv
package motion_pkg;

	// image geometry, kept small for simulation
	localparam int image_w = 64;
	localparam int image_h = 48;

	localparam int x_width = 6;
	localparam int y_width = 6;
	localparam int colour_width = 3;

	localparam int pix_addr_width = 12;   // image_w * image_h = 3072
	localparam int count_width = 13;

	// plotted ones per frame needed to flag motion
	localparam int motion_threshold = 40;

	typedef logic [pix_addr_width-1:0] pix_addr_t;

	typedef enum logic [1:0] {
		idle,
		request,
		wait_data,
		emit
	} scan_state_t;

endpackage

// File: design/motion_top.sv
`timescale 1ns/10ps

module motion_top (
	input  logic                                clock,
	input  logic                                rst_n,
	input  logic                                pixel_valid,
	input  logic [motion_pkg::x_width-1:0]     pixel_x,
	input  logic [motion_pkg::y_width-1:0]     pixel_y,
	input  logic [motion_pkg::colour_width-1:0] pixel_colour,
	input  logic                                frame_start,
	input  logic                                smoothing,
	output logic                                plot,
	output logic [motion_pkg::x_width-1:0]     plot_x,
	output logic [motion_pkg::y_width-1:0]     plot_y,
	output logic                                plot_colour,
	output logic                                frame_done,
	output logic [motion_pkg::count_width-1:0] motion_count,
	output logic                                motion_detected
);
	import motion_pkg::*;

	pix_addr_t               fs_rd_addr;
	logic [colour_width-1:0] fs_rd_colour;
	logic                    fs_wr_en;
	pix_addr_t               fs_wr_addr;
	logic [colour_width-1:0] fs_wr_colour;

	logic                    mask_wr;
	pix_addr_t               mask_wr_addr;
	logic                    mask_wr_bit;

	logic                    mask_rd_req;
	pix_addr_t               mask_rd_addr;
	logic                    mask_rd_grant;
	logic                    mask_rd_valid;
	logic                    mask_rd_bit;

	frame_store u_frame_store (
		.clock     (clock),
		.rd_addr   (fs_rd_addr),
		.rd_colour (fs_rd_colour),
		.wr_en     (fs_wr_en),
		.wr_addr   (fs_wr_addr),
		.wr_colour (fs_wr_colour)
	);

	diff_engine u_diff_engine (
		.clock        (clock),
		.rst_n        (rst_n),
		.pixel_valid  (pixel_valid),
		.pixel_x      (pixel_x),
		.pixel_y      (pixel_y),
		.pixel_colour (pixel_colour),
		.fs_rd_addr   (fs_rd_addr),
		.fs_rd_colour (fs_rd_colour),
		.fs_wr_en     (fs_wr_en),
		.fs_wr_addr   (fs_wr_addr),
		.fs_wr_colour (fs_wr_colour),
		.mask_wr      (mask_wr),
		.mask_addr    (mask_wr_addr),
		.mask_bit     (mask_wr_bit)
	);

	mask_arbiter u_mask_arbiter (
		.clock     (clock),
		.rst_n     (rst_n),
		.wr_strobe (mask_wr),
		.wr_addr   (mask_wr_addr),
		.wr_bit    (mask_wr_bit),
		.rd_req    (mask_rd_req),
		.rd_addr   (mask_rd_addr),
		.rd_grant  (mask_rd_grant),
		.rd_valid  (mask_rd_valid),
		.rd_bit    (mask_rd_bit)
	);

	mask_scanner u_mask_scanner (
		.clock           (clock),
		.rst_n           (rst_n),
		.frame_start     (frame_start),
		.smoothing       (smoothing),
		.rd_req          (mask_rd_req),
		.rd_addr         (mask_rd_addr),
		.rd_grant        (mask_rd_grant),
		.rd_valid        (mask_rd_valid),
		.rd_bit          (mask_rd_bit),
		.plot            (plot),
		.plot_x          (plot_x),
		.plot_y          (plot_y),
		.plot_colour     (plot_colour),
		.frame_done      (frame_done),
		.motion_count    (motion_count),
		.motion_detected (motion_detected)
	);

endmodule

// File: list.f
design/motion_pkg.sv
design/frame_store.sv
design/diff_engine.sv
design/mask_ram.sv
design/mask_arbiter.sv
design/mask_scanner.sv
design/motion_top.sv
bench/motion_assert.sv
bench/motion_tb.sv
